// ==== design/debug_trig_pkg.sv ====
/* Debug trigger package
   Trigger type codes, tdata1 field positions, privilege levels and CSR constants */

package debug_trig_pkg;

  // Widths
  localparam int CSR_W       = 32;
  localparam int EXC_CAUSE_W = 11;

  // Privilege levels seen by the trigger logic
  typedef enum logic [1:0] {
    PRIV_LVL_U = 2'b00,
    PRIV_LVL_M = 2'b11
  } priv_lvl_t;

  // mcontrol6 match rule, WARL (0, 2, 3)
  typedef enum logic [1:0] {
    MATCH_EQ = 2'd0,  // Address equal
    MATCH_GE = 2'd2,  // Address greater or equal
    MATCH_LT = 2'd3   // Address less than
  } match_mode_e;

  //////////////////////////////////////////////////////////////////////
  // tdata1 type codes and field positions
  //////////////////////////////////////////////////////////////////////

  localparam logic [3:0] TTYPE_ETRIGGER  = 4'h5;
  localparam logic [3:0] TTYPE_MCONTROL6 = 4'h6;
  localparam logic [3:0] TTYPE_DISABLED  = 4'hF;

  localparam int TDATA1_TTYPE_HIGH = 31;
  localparam int TDATA1_TTYPE_LOW  = 28;

  // mcontrol6 fields
  localparam int MC6_MATCH_HIGH = 10;
  localparam int MC6_MATCH_LOW  = 7;
  localparam int MC6_M          = 6;
  localparam int MC6_U          = 3;
  localparam int MC6_EXECUTE    = 2;
  localparam int MC6_STORE      = 1;
  localparam int MC6_LOAD       = 0;

  // etrigger fields
  localparam int ETRIG_M = 9;
  localparam int ETRIG_U = 6;

  //////////////////////////////////////////////////////////////////////
  // Constant values
  //////////////////////////////////////////////////////////////////////

  // Exception causes with an implemented etrigger bit
  // Causes 0, 1, 2, 3, 5, 7, 8, 11, 24 and 25
  localparam logic [CSR_W-1:0] ETRIG_TDATA2_MASK = 32'h0300_09AF;

  // Disabled type, dmode set, everything else zero
  localparam logic [CSR_W-1:0] TDATA1_RST_VAL = {TTYPE_DISABLED, 1'b1, 27'd0};

  // Supported types: etrigger (5), mcontrol6 (6), disabled (15)
  localparam logic [CSR_W-1:0] TINFO_VAL = 32'h0000_8060;

endpackage

// ==== design/trigger_cfg_if.sv ====
/* Trigger configuration interface
   Decoded per-trigger fields from the CSR bank to the three matchers */

`timescale 1ns/1ps

interface trigger_cfg_if #(
  parameter int NUM_TRIGGERS = 2
);
  import debug_trig_pkg::*;

  logic [NUM_TRIGGERS-1:0] is_mc6;              // Type is mcontrol6
  logic [NUM_TRIGGERS-1:0] is_etrig;            // Type is etrigger
  match_mode_e             match_mode [NUM_TRIGGERS];
  logic [NUM_TRIGGERS-1:0] m_en;                // Match in machine mode
  logic [NUM_TRIGGERS-1:0] u_en;                // Match in user mode
  logic [NUM_TRIGGERS-1:0] exec_en;
  logic [NUM_TRIGGERS-1:0] load_en;
  logic [NUM_TRIGGERS-1:0] store_en;
  logic [CSR_W-1:0]        tdata2 [NUM_TRIGGERS]; // Match address or cause bitmap

  // CSR bank side
  modport bank (
    output is_mc6, is_etrig, match_mode, m_en, u_en,
    output exec_en, load_en, store_en, tdata2
  );

  // Match stage side
  modport matcher (
    input is_mc6, is_etrig, match_mode, m_en, u_en,
    input exec_en, load_en, store_en, tdata2
  );

endinterface

// ==== design/trigger_csr_bank.sv ====
/* Trigger CSR bank
   WARL write resolution of tselect/tdata1/tdata2, trigger registers, decode and read mux */

`timescale 1ns/1ps

module trigger_csr_bank #(
  parameter int NUM_TRIGGERS = 2
) (
  input  logic                           clk,
  input  logic                           rst_n_i,

  // CSR write port
  input  logic [debug_trig_pkg::CSR_W-1:0] csr_wdata_i,
  input  logic                           tselect_we_i,
  input  logic                           tdata1_we_i,
  input  logic                           tdata2_we_i,

  // CSR read data
  output logic [debug_trig_pkg::CSR_W-1:0] tselect_rdata_o,
  output logic [debug_trig_pkg::CSR_W-1:0] tdata1_rdata_o,
  output logic [debug_trig_pkg::CSR_W-1:0] tdata2_rdata_o,
  output logic [debug_trig_pkg::CSR_W-1:0] tinfo_rdata_o,

  trigger_cfg_if.bank                    cfg
);
  import debug_trig_pkg::*;

  // Trigger registers
  logic [CSR_W-1:0] tselect_q;
  logic [CSR_W-1:0] tdata1_q [NUM_TRIGGERS];
  logic [CSR_W-1:0] tdata2_q [NUM_TRIGGERS];

  // Resolved write data
  logic [CSR_W-1:0] tselect_n;
  logic [CSR_W-1:0] tdata1_n;
  logic [CSR_W-1:0] tdata2_n;

  logic [3:0] wr_ttype;       // Type field of the write data
  logic [3:0] wr_match;       // Raw match field
  logic [3:0] wr_match_res;   // Match field after WARL
  logic       sel_is_etrig;   // Selected trigger currently an etrigger

  assign wr_ttype     = csr_wdata_i[TDATA1_TTYPE_HIGH:TDATA1_TTYPE_LOW];
  assign wr_match     = csr_wdata_i[MC6_MATCH_HIGH:MC6_MATCH_LOW];
  assign wr_match_res = ((wr_match == 4'd2) || (wr_match == 4'd3)) ? wr_match : 4'd0; // 1, >3 -> EQ
  assign sel_is_etrig = (tdata1_rdata_o[TDATA1_TTYPE_HIGH:TDATA1_TTYPE_LOW] == TTYPE_ETRIGGER);

  //////////////////////////////////////////////////////////////////////
  // WARL write resolution
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    // Out of range tselect keeps the old index
    tselect_n = (csr_wdata_i < NUM_TRIGGERS) ? csr_wdata_i : tselect_q;

    case (wr_ttype)
      TTYPE_MCONTROL6: begin
        tdata1_n = {TTYPE_MCONTROL6,
                    1'b1,                       // dmode
                    2'b00, 3'b000,              // Zero, vs/vu/hit
                    1'b0, 1'b0,                 // select, timing
                    4'b0000,                    // size, any
                    4'b0001,                    // action, enter debug
                    1'b0,                       // chain
                    wr_match_res,
                    csr_wdata_i[MC6_M],
                    1'b0, 1'b0,                 // Zero, S
                    csr_wdata_i[MC6_U],
                    csr_wdata_i[MC6_EXECUTE],
                    csr_wdata_i[MC6_STORE],
                    csr_wdata_i[MC6_LOAD]};
      end
      TTYPE_ETRIGGER: begin
        // Causes outside the implemented set force a disabled trigger
        if (|(tdata2_rdata_o & ~ETRIG_TDATA2_MASK)) begin
          tdata1_n = TDATA1_RST_VAL;
        end else begin
          tdata1_n = {TTYPE_ETRIGGER,
                      1'b1,                     // dmode
                      1'b0, 13'd0,              // hit, zero
                      1'b0, 1'b0, 1'b0,         // vs, vu, zero
                      csr_wdata_i[ETRIG_M],
                      1'b0, 1'b0,               // Zero, S
                      csr_wdata_i[ETRIG_U],
                      6'b000001};               // action, enter debug
        end
      end
      default: tdata1_n = TDATA1_RST_VAL;   // Disabled or unsupported type
    endcase

    // Etrigger only keeps implemented cause bits
    tdata2_n = sel_is_etrig ? (csr_wdata_i & ETRIG_TDATA2_MASK) : csr_wdata_i;
  end

  //////////////////////////////////////////////////////////////////////
  // Registers
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (!rst_n_i) begin
      tselect_q <= '0;
      for (int i = 0; i < NUM_TRIGGERS; i++) begin
        tdata1_q[i] <= TDATA1_RST_VAL;
        tdata2_q[i] <= '0;
      end
    end else begin
      if (tselect_we_i) tselect_q <= tselect_n;
      for (int i = 0; i < NUM_TRIGGERS; i++) begin
        if (tdata1_we_i && (tselect_q == i)) tdata1_q[i] <= tdata1_n;
        if (tdata2_we_i && (tselect_q == i)) tdata2_q[i] <= tdata2_n;
      end
    end
  end

  // Field decode, done once for all matchers
  always_comb begin
    for (int i = 0; i < NUM_TRIGGERS; i++) begin
      cfg.is_mc6[i]     = (tdata1_q[i][TDATA1_TTYPE_HIGH:TDATA1_TTYPE_LOW] == TTYPE_MCONTROL6);
      cfg.is_etrig[i]   = (tdata1_q[i][TDATA1_TTYPE_HIGH:TDATA1_TTYPE_LOW] == TTYPE_ETRIGGER);
      cfg.match_mode[i] = match_mode_e'(tdata1_q[i][MC6_MATCH_LOW+1:MC6_MATCH_LOW]);
      cfg.m_en[i]       = cfg.is_etrig[i] ? tdata1_q[i][ETRIG_M] : tdata1_q[i][MC6_M];
      cfg.u_en[i]       = cfg.is_etrig[i] ? tdata1_q[i][ETRIG_U] : tdata1_q[i][MC6_U];
      cfg.exec_en[i]    = tdata1_q[i][MC6_EXECUTE];
      cfg.load_en[i]    = tdata1_q[i][MC6_LOAD];
      cfg.store_en[i]   = tdata1_q[i][MC6_STORE];
      cfg.tdata2[i]     = tdata2_q[i];
    end
  end

  // Read mux on the selected trigger
  always_comb begin
    tdata1_rdata_o = tdata1_q[0];
    tdata2_rdata_o = tdata2_q[0];
    for (int i = 1; i < NUM_TRIGGERS; i++) begin
      if (tselect_q == i) begin
        tdata1_rdata_o = tdata1_q[i];
        tdata2_rdata_o = tdata2_q[i];
      end
    end
  end

  assign tselect_rdata_o = tselect_q;
  assign tinfo_rdata_o   = TINFO_VAL;   // Read only

endmodule

// ==== design/exec_addr_match.sv ====
/* Instruction address trigger
   Compares the IF stage PC with each mcontrol6 trigger that has execute set */

`timescale 1ns/1ps

module exec_addr_match #(
  parameter int NUM_TRIGGERS = 2
) (
  input  logic [debug_trig_pkg::CSR_W-1:0] pc_if_i,
  input  debug_trig_pkg::priv_lvl_t        priv_lvl_if_i,
  input  logic                             debug_mode_i,
  output logic                             trigger_match_if_o,

  trigger_cfg_if.matcher                   cfg
);
  import debug_trig_pkg::*;

  logic [NUM_TRIGGERS-1:0] addr_hit;   // Address rule satisfied
  logic [NUM_TRIGGERS-1:0] priv_hit;   // Enabled in current privilege
  logic [NUM_TRIGGERS-1:0] trig_hit;

  always_comb begin
    for (int i = 0; i < NUM_TRIGGERS; i++) begin
      case (cfg.match_mode[i])
        MATCH_EQ: addr_hit[i] = (pc_if_i == cfg.tdata2[i]);
        MATCH_GE: addr_hit[i] = (pc_if_i >= cfg.tdata2[i]);
        default:  addr_hit[i] = (pc_if_i <  cfg.tdata2[i]); // LT
      endcase

      priv_hit[i] = (cfg.m_en[i] && (priv_lvl_if_i == PRIV_LVL_M)) ||
                    (cfg.u_en[i] && (priv_lvl_if_i == PRIV_LVL_U));

      // No matching while in debug mode
      trig_hit[i] = cfg.is_mc6[i] && cfg.exec_en[i] && priv_hit[i] &&
                    addr_hit[i] && !debug_mode_i;
    end
  end

  assign trigger_match_if_o = |trig_hit;

endmodule

// ==== design/lsu_addr_match.sv ====
/* Load/store address trigger
   Matches the EX stage access, with byte enables giving the accessed range */

`timescale 1ns/1ps

module lsu_addr_match #(
  parameter int NUM_TRIGGERS = 2
) (
  input  logic                             lsu_valid_ex_i,
  input  logic [debug_trig_pkg::CSR_W-1:0] lsu_addr_ex_i,
  input  logic                             lsu_we_ex_i,     // 1 = store
  input  logic [3:0]                       lsu_be_ex_i,
  input  debug_trig_pkg::priv_lvl_t        priv_lvl_ex_i,
  input  logic                             debug_mode_i,
  output logic                             trigger_match_ex_o,

  trigger_cfg_if.matcher                   cfg
);
  import debug_trig_pkg::*;

  logic [1:0]       low_lsb;     // Lowest enabled byte
  logic [1:0]       high_lsb;    // Highest enabled byte
  logic [CSR_W-1:0] addr_low;
  logic [CSR_W-1:0] addr_high;

  logic [3:0]              byte_hit [NUM_TRIGGERS]; // Enabled byte at tdata2[1:0]
  logic [NUM_TRIGGERS-1:0] addr_hit;
  logic [NUM_TRIGGERS-1:0] access_en;   // Load/store kind enabled
  logic [NUM_TRIGGERS-1:0] priv_hit;
  logic [NUM_TRIGGERS-1:0] trig_hit;

  //////////////////////////////////////////////////////////////////////
  // Accessed byte range
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    low_lsb  = 2'd0;
    high_lsb = 2'd0;
    for (int b = 0; b < 4; b++) begin
      if (lsu_be_ex_i[b]) high_lsb = 2'(b);   // Last set wins
    end
    for (int b = 3; b >= 0; b--) begin
      if (lsu_be_ex_i[b]) low_lsb = 2'(b);
    end
  end

  assign addr_low  = {lsu_addr_ex_i[CSR_W-1:2], low_lsb};
  assign addr_high = {lsu_addr_ex_i[CSR_W-1:2], high_lsb};

  // Per trigger match
  always_comb begin
    for (int i = 0; i < NUM_TRIGGERS; i++) begin
      for (int b = 0; b < 4; b++) begin
        byte_hit[i][b] = lsu_be_ex_i[b] && (2'(b) == cfg.tdata2[i][1:0]);
      end

      case (cfg.match_mode[i])
        MATCH_EQ: addr_hit[i] = (lsu_addr_ex_i[CSR_W-1:2] == cfg.tdata2[i][CSR_W-1:2]) &&
                                (|byte_hit[i]);
        MATCH_GE: addr_hit[i] = (addr_high >= cfg.tdata2[i]);  // Any byte at or above
        default:  addr_hit[i] = (addr_low  <  cfg.tdata2[i]);  // Any byte below
      endcase

      access_en[i] = lsu_valid_ex_i && ((cfg.load_en[i]  && !lsu_we_ex_i) ||
                                        (cfg.store_en[i] &&  lsu_we_ex_i));

      priv_hit[i] = (cfg.m_en[i] && (priv_lvl_ex_i == PRIV_LVL_M)) ||
                    (cfg.u_en[i] && (priv_lvl_ex_i == PRIV_LVL_U));

      trig_hit[i] = cfg.is_mc6[i] && access_en[i] && priv_hit[i] &&
                    addr_hit[i] && !debug_mode_i;
    end
  end

  assign trigger_match_ex_o = |trig_hit;

endmodule

// ==== design/exc_trigger_match.sv ====
/* Exception trigger
   Fires on a WB stage exception whose cause bit is set in an etrigger's tdata2 */

`timescale 1ns/1ps

module exc_trigger_match #(
  parameter int NUM_TRIGGERS = 2
) (
  input  logic                                   exception_in_wb_i,
  input  logic [debug_trig_pkg::EXC_CAUSE_W-1:0] exception_cause_wb_i,
  input  debug_trig_pkg::priv_lvl_t              priv_lvl_wb_i,
  input  logic                                   debug_mode_i,
  output logic                                   etrigger_wb_o,

  trigger_cfg_if.matcher                         cfg
);
  import debug_trig_pkg::*;

  logic                    cause_valid;   // Cause fits the 32 bit tdata2 bitmap
  logic [NUM_TRIGGERS-1:0] priv_hit;
  logic [NUM_TRIGGERS-1:0] trig_hit;

  assign cause_valid = exception_in_wb_i && (exception_cause_wb_i < EXC_CAUSE_W'(32));

  always_comb begin
    for (int i = 0; i < NUM_TRIGGERS; i++) begin
      priv_hit[i] = (cfg.m_en[i] && (priv_lvl_wb_i == PRIV_LVL_M)) ||
                    (cfg.u_en[i] && (priv_lvl_wb_i == PRIV_LVL_U));

      trig_hit[i] = cfg.is_etrig[i] && cause_valid &&
                    cfg.tdata2[i][exception_cause_wb_i[4:0]] &&
                    priv_hit[i] && !debug_mode_i;
    end
  end

  assign etrigger_wb_o = |trig_hit;

endmodule

// ==== design/debug_triggers.sv ====
/* Debug trigger top
   CSR bank feeding the IF, EX and WB trigger match stages */

`timescale 1ns/1ps

module debug_triggers #(
  parameter int NUM_TRIGGERS = 2   // 1 to 4
) (
  input  logic                                   clk,
  input  logic                                   rst_n_i,

  // CSR write
  input  logic [debug_trig_pkg::CSR_W-1:0]       csr_wdata_i,
  input  logic                                   tselect_we_i,
  input  logic                                   tdata1_we_i,
  input  logic                                   tdata2_we_i,

  // CSR read
  output logic [debug_trig_pkg::CSR_W-1:0]       tselect_rdata_o,
  output logic [debug_trig_pkg::CSR_W-1:0]       tdata1_rdata_o,
  output logic [debug_trig_pkg::CSR_W-1:0]       tdata2_rdata_o,
  output logic [debug_trig_pkg::CSR_W-1:0]       tinfo_rdata_o,

  // IF stage
  input  logic [debug_trig_pkg::CSR_W-1:0]       pc_if_i,
  input  debug_trig_pkg::priv_lvl_t              priv_lvl_if_i,

  // EX stage
  input  logic                                   lsu_valid_ex_i,
  input  logic [debug_trig_pkg::CSR_W-1:0]       lsu_addr_ex_i,
  input  logic                                   lsu_we_ex_i,
  input  logic [3:0]                             lsu_be_ex_i,
  input  debug_trig_pkg::priv_lvl_t              priv_lvl_ex_i,

  // WB stage
  input  debug_trig_pkg::priv_lvl_t              priv_lvl_wb_i,
  input  logic                                   exception_in_wb_i,
  input  logic [debug_trig_pkg::EXC_CAUSE_W-1:0] exception_cause_wb_i,

  input  logic                                   debug_mode_i,

  // Match levels
  output logic                                   trigger_match_if_o,
  output logic                                   trigger_match_ex_o,
  output logic                                   etrigger_wb_o
);

  trigger_cfg_if #(.NUM_TRIGGERS(NUM_TRIGGERS)) cfg_if ();

  trigger_csr_bank #(.NUM_TRIGGERS(NUM_TRIGGERS)) u_csr_bank (
    .clk,
    .rst_n_i,
    .csr_wdata_i,
    .tselect_we_i,
    .tdata1_we_i,
    .tdata2_we_i,
    .tselect_rdata_o,
    .tdata1_rdata_o,
    .tdata2_rdata_o,
    .tinfo_rdata_o,
    .cfg              (cfg_if.bank)
  );

  // Instruction address, IF
  exec_addr_match #(.NUM_TRIGGERS(NUM_TRIGGERS)) u_exec_match (
    .pc_if_i,
    .priv_lvl_if_i,
    .debug_mode_i,
    .trigger_match_if_o,
    .cfg              (cfg_if.matcher)
  );

  // Load/store address, EX
  lsu_addr_match #(.NUM_TRIGGERS(NUM_TRIGGERS)) u_lsu_match (
    .lsu_valid_ex_i,
    .lsu_addr_ex_i,
    .lsu_we_ex_i,
    .lsu_be_ex_i,
    .priv_lvl_ex_i,
    .debug_mode_i,
    .trigger_match_ex_o,
    .cfg              (cfg_if.matcher)
  );

  // Exception, WB
  exc_trigger_match #(.NUM_TRIGGERS(NUM_TRIGGERS)) u_exc_match (
    .exception_in_wb_i,
    .exception_cause_wb_i,
    .priv_lvl_wb_i,
    .debug_mode_i,
    .etrigger_wb_o,
    .cfg              (cfg_if.matcher)
  );

endmodule

// ==== tb/tb_debug_triggers.sv ====
/* Debug trigger testbench
   Replays the golden operation file on the trigger block and checks every response */

`timescale 1ns/1ps

module tb_debug_triggers;

  localparam int          MAX_OPS    = 200;            // Bound on golden file length
  localparam int          OPEN_TRIES = 4;              // Attempts to open the golden file
  localparam logic [31:0] TINFO_EXP  = 32'h0000_8060;  // Types 5, 6 and 15 supported

  logic                                 clk;
  logic                                 rst_n_i;
  logic [31:0]                          csr_wdata_i;
  logic                                 tselect_we_i;
  logic                                 tdata1_we_i;
  logic                                 tdata2_we_i;
  logic [31:0]                          tselect_rdata_o;
  logic [31:0]                          tdata1_rdata_o;
  logic [31:0]                          tdata2_rdata_o;
  logic [31:0]                          tinfo_rdata_o;
  logic [31:0]                          pc_if_i;
  debug_trig_pkg::priv_lvl_t            priv_lvl_if_i;
  logic                                 lsu_valid_ex_i;
  logic [31:0]                          lsu_addr_ex_i;
  logic                                 lsu_we_ex_i;
  logic [3:0]                           lsu_be_ex_i;
  debug_trig_pkg::priv_lvl_t            priv_lvl_ex_i;
  debug_trig_pkg::priv_lvl_t            priv_lvl_wb_i;
  logic                                 exception_in_wb_i;
  logic [debug_trig_pkg::EXC_CAUSE_W-1:0] exception_cause_wb_i;
  logic                                 debug_mode_i;
  logic                                 trigger_match_if_o;
  logic                                 trigger_match_ex_o;
  logic                                 etrigger_wb_o;

  debug_triggers #(.NUM_TRIGGERS(2)) dut (.*);

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;   // 10 ns period
  end

  //////////////////////////////////////////////////////////////////////
  // Checking and error exit
  //////////////////////////////////////////////////////////////////////

  task automatic abort_run();
    $display("TESTS FAILED");
    $fatal(1, "Stopped at first error");
  endtask

  task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      $display("mismatch at time %0t: %s got %h expected %h", $realtime, name, got, exp);
      abort_run();
    end
  endtask

  task automatic report_bad_line(input logic [7:0] op);
    $display("Golden file line with opcode %c has wrong fields", op);
    abort_run();
  endtask

  // Drops the rest of a comment line
  task automatic skip_line(input integer fd);
    integer ch;
    ch = 0;
    for (int i = 0; i < 200 && ch != 10 && ch != -1; i++) begin
      ch = $fgetc(fd);
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // Operations, all driven on the falling edge
  //////////////////////////////////////////////////////////////////////

  task automatic write_csr(input logic [31:0] sel, input logic [31:0] data);
    @(negedge clk);
    csr_wdata_i  = data;
    tselect_we_i = (sel == 0);
    tdata1_we_i  = (sel == 1);
    tdata2_we_i  = (sel == 2);
    @(negedge clk);   // Strobe seen by exactly one rising edge
    tselect_we_i = 1'b0;
    tdata1_we_i  = 1'b0;
    tdata2_we_i  = 1'b0;
  endtask

  task automatic check_read(input logic [31:0] ts, input logic [31:0] t1, input logic [31:0] t2);
    @(posedge clk);   // No strobe active, registers steady
    check_val("tselect_rdata_o", tselect_rdata_o, ts);
    check_val("tdata1_rdata_o", tdata1_rdata_o, t1);
    check_val("tdata2_rdata_o", tdata2_rdata_o, t2);
    check_val("tinfo_rdata_o", tinfo_rdata_o, TINFO_EXP);
  endtask

  task automatic run_fetch(input logic [31:0] pc, input logic [31:0] priv,
                           input logic [31:0] dbg, input logic [31:0] exp);
    @(negedge clk);
    pc_if_i       = pc;
    priv_lvl_if_i = debug_trig_pkg::priv_lvl_t'(priv[1:0]);
    debug_mode_i  = dbg[0];   // Stays for the following L and E lines
    @(posedge clk);
    check_val("trigger_match_if_o", trigger_match_if_o, exp);
  endtask

  task automatic run_access(input logic [31:0] valid, input logic [31:0] addr,
                            input logic [31:0] we, input logic [31:0] be,
                            input logic [31:0] priv, input logic [31:0] exp);
    @(negedge clk);
    lsu_valid_ex_i = valid[0];
    lsu_addr_ex_i  = addr;
    lsu_we_ex_i    = we[0];   // 1 = store
    lsu_be_ex_i    = be[3:0];
    priv_lvl_ex_i  = debug_trig_pkg::priv_lvl_t'(priv[1:0]);
    @(posedge clk);
    check_val("trigger_match_ex_o", trigger_match_ex_o, exp);
  endtask

  task automatic run_exception(input logic [31:0] valid, input logic [31:0] cause,
                               input logic [31:0] priv, input logic [31:0] exp);
    @(negedge clk);
    exception_in_wb_i    = valid[0];
    exception_cause_wb_i = cause[debug_trig_pkg::EXC_CAUSE_W-1:0];
    priv_lvl_wb_i        = debug_trig_pkg::priv_lvl_t'(priv[1:0]);
    @(posedge clk);
    check_val("etrigger_wb_o", etrigger_wb_o, exp);
  endtask

  //////////////////////////////////////////////////////////////////////
  // Main sequence
  //////////////////////////////////////////////////////////////////////

  initial begin
    integer      fd;
    integer      n;
    logic [7:0]  op;
    logic [31:0] f0, f1, f2, f3, f4, f5;
    bit          done;

    rst_n_i              = 1'b0;
    csr_wdata_i          = '0;
    tselect_we_i         = 1'b0;
    tdata1_we_i          = 1'b0;
    tdata2_we_i          = 1'b0;
    pc_if_i              = '0;
    priv_lvl_if_i        = debug_trig_pkg::PRIV_LVL_M;
    lsu_valid_ex_i       = 1'b0;
    lsu_addr_ex_i        = '0;
    lsu_we_ex_i          = 1'b0;
    lsu_be_ex_i          = '0;
    priv_lvl_ex_i        = debug_trig_pkg::PRIV_LVL_M;
    priv_lvl_wb_i        = debug_trig_pkg::PRIV_LVL_M;
    exception_in_wb_i    = 1'b0;
    exception_cause_wb_i = '0;
    debug_mode_i         = 1'b0;
    repeat (5) @(posedge clk);   // Reset held for 5 cycles
    @(negedge clk);
    rst_n_i = 1'b1;

    fd = 0;
    for (int t = 0; t < OPEN_TRIES && fd == 0; t++) begin
      fd = $fopen("tb/debug_triggers_golden.txt", "r");
      if (fd == 0) @(negedge clk);
    end
    if (fd == 0) begin
      $display("Could not open tb/debug_triggers_golden.txt");
      abort_run();
    end

    done = 1'b0;
    for (int k = 0; k < MAX_OPS && !done; k++) begin
      n = $fscanf(fd, " %c", op);
      if (n != 1) begin
        done = 1'b1;   // End of file
      end else begin
        case (op)
          "#": skip_line(fd);
          "W": begin
            n = $fscanf(fd, "%h %h", f0, f1);
            if (n != 2 || f0 > 2) report_bad_line(op);
            else write_csr(f0, f1);
          end
          "R": begin
            n = $fscanf(fd, "%h %h %h", f0, f1, f2);
            if (n != 3) report_bad_line(op);
            else check_read(f0, f1, f2);
          end
          "I": begin
            n = $fscanf(fd, "%h %h %h %h", f0, f1, f2, f3);
            if (n != 4) report_bad_line(op);
            else run_fetch(f0, f1, f2, f3);
          end
          "L": begin
            n = $fscanf(fd, "%h %h %h %h %h %h", f0, f1, f2, f3, f4, f5);
            if (n != 6) report_bad_line(op);
            else run_access(f0, f1, f2, f3, f4, f5);
          end
          "E": begin
            n = $fscanf(fd, "%h %h %h %h", f0, f1, f2, f3);
            if (n != 4) report_bad_line(op);
            else run_exception(f0, f1, f2, f3);
          end
          default: report_bad_line(op);
        endcase
      end
    end
    if (!done) begin
      $display("Golden file runs past %0d operations", MAX_OPS);
      abort_run();
    end else begin
      $fclose(fd);
      $display("TESTS PASSED");
      $finish;
    end
  end

endmodule

// ==== tb/debug_triggers_golden.txt ====
# Hex fields. W sel data (sel 0 tselect, 1 tdata1, 2 tdata2) | R tselect tdata1 tdata2
# I pc priv dbg if_match | L valid addr we be priv ex_match | E exc cause priv wb_match
# priv 3 = M, 0 = U; dbg from an I line stays applied until the next I line
R 0 F8000000 00000000
I 00001000 3 0 0
L 1 00001000 0 F 3 0
E 1 2 3 0
W 0 00000005
R 0 F8000000 00000000
W 0 00000001
W 1 600000C4
R 1 68001044 00000000
W 1 30000044
R 1 F8000000 00000000
W 0 00000000
W 2 00000010
W 1 50000240
R 0 F8000000 00000010
W 2 00000800
W 1 50000240
W 2 FFFFFFFF
R 0 58000241 030009AF
E 1 2 3 1
E 1 4 3 0
E 0 2 3 0
W 0 00000001
W 1 60000044
W 2 00001000
I 00001000 3 0 1
I 00000FFC 3 0 0
I 00001004 3 0 0
W 1 6000010C
I 00001000 0 0 1
I 00000FFC 0 0 0
I 00001004 0 0 1
I 00001004 3 0 0
W 1 600001C4
R 1 680011C4 00001000
I 00001000 3 0 0
I 00000FFC 3 0 1
I 00001004 3 0 0
W 1 60000043
W 2 00002002
L 1 00002000 0 C 3 1
L 1 00002000 0 3 3 0
L 0 00002000 0 C 3 0
W 1 60000143
W 2 00002003
L 1 00002000 1 8 3 1
L 1 00002000 1 7 3 0
W 1 60000141
L 1 00002000 1 8 3 0
L 1 00002000 0 8 3 1
W 1 60000145
I 00002003 3 0 1
I 00002003 3 1 0
L 1 00002000 0 8 3 0
E 1 2 3 0

// ==== tb.f ====
design/debug_trig_pkg.sv
design/trigger_cfg_if.sv
design/trigger_csr_bank.sv
design/exec_addr_match.sv
design/lsu_addr_match.sv
design/exc_trigger_match.sv
design/debug_triggers.sv
tb/tb_debug_triggers.sv
